//--- build.f
logic/s16b_pkg.sv
logic/s16b_bus_decode.sv
logic/s16b_cab_io.sv
logic/s16b_data_ack.sv
logic/s16b_main.sv
test/s16b_main_checker.sv
test/tb_s16b_main.sv

//--- Makefile
SRCS := $(wildcard logic/*.sv test/*.sv)

obj_dir/Vtb_s16b_main: build.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_s16b_main -f build.f

run: obj_dir/Vtb_s16b_main
	./obj_dir/Vtb_s16b_main

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- test/tb_s16b_main.sv
// Bus glue testbench
// Directed CPU bus cycles against the main board glue
`timescale 1ns/100ps

module tb_s16b_main;

    localparam int SEL_ROM = 0;   // Bit positions of the select vector
    localparam int SEL_PAL = 4;
    localparam int SEL_IO  = 6;

    logic                   clk;
    logic                   rst;
    logic                   cpu_cen = 1'b0;
    s16b_pkg::cpu_addr_t    addr;
    s16b_pkg::bus_word_t    cpu_dout;
    logic                   rnw, uds_n, lds_n, as_n, bgack_n;
    logic                   uds_wn, lds_wn, dtack_n;
    s16b_pkg::bus_word_t    cpu_din;
    s16b_pkg::region_mask_t active;
    s16b_pkg::board_id_t    board_id;
    s16b_pkg::dtack_cyc_t   dtack_cyc;
    logic                   rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    s16b_pkg::rom_addr_t    rom_addr;
    s16b_pkg::bus_word_t    rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic                   rom_ok, ram_ok;
    s16b_pkg::cab_byte_t    joystick1, joystick2, dipsw_a, dipsw_b;
    logic [1:0]             start_button, coin_input;
    logic                   service, dip_test;
    logic                   flip, video_en;
    s16b_pkg::tile_bank_t   tile_bank;
    logic [31:0]            rng = 32'hbd728c6c;

    s16b_main u_s16b_main (.*);

    bind s16b_main s16b_main_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .as_n      (as_n),
        .dtack_n   (dtack_n),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cpu_cen <= rst ? 1'b0 : ~cpu_cen;   // Every other cycle

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input s16b_pkg::bus_word_t got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input s16b_pkg::cab_byte_t got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_rom_addr(input string name, input s16b_pkg::rom_addr_t got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_tile_bank(input string name, input s16b_pkg::tile_bank_t got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_sels(input logic [7:0] got, exp);
        if (got !== exp)
            fail_now($sformatf("** Error at %0t: selects = %b, expected %b", $time, got, exp));
    endtask

    // {tbank, io, obj, pal, char, vram, ram, rom}
    function automatic logic [7:0] cur_sels();
        return {u_s16b_main.tbank_cs, u_s16b_main.io_cs, objram_cs, pal_cs,
                char_cs, vram_cs, ram_cs, rom_cs};
    endfunction

    function automatic s16b_pkg::rom_addr_t rom_addr_model(input s16b_pkg::board_id_t id,
                                                          input logic [1:0] bank,
                                                          input s16b_pkg::cpu_addr_t a);
        if (id >= 8'h20 && id <= 8'h3f)
            return a[18:1];
        else if (id >= 8'h08 && id <= 8'h0f)
            return {1'b0, a[17:1]};
        else if (id == 8'h10 || id == 8'h1a)
            return {bank, a[16:1]};
        else if (id >= 8'h10 && id <= 8'h1f)
            return {1'b0, bank, a[15:1]};
        return {bank[0], a[17:1]};
    endfunction

    function automatic s16b_pkg::cab_byte_t joy_remap(input s16b_pkg::cab_byte_t j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    function automatic s16b_pkg::cab_byte_t cab_model(input s16b_pkg::cpu_addr_t a);
        if (a[13:12] == s16b_pkg::IO_INPUTS) begin
            case (a[2:1])
                2'd0:    return {2'b11, start_button, service, dip_test, coin_input};
                2'd1:    return joy_remap(joystick1);
                2'd3:    return joy_remap(joystick2);
                default: return 8'hff;
            endcase
        end
        if (a[13:12] == s16b_pkg::IO_DIP)
            return a[1] ? dipsw_a : dipsw_b;
        return 8'hff;
    endfunction

    // New memory words and cabinet inputs
    task automatic load_random_inputs();
        logic [31:0] r1, r2, r3, r4;
        r1 = xorshift();
        r2 = xorshift();
        r3 = xorshift();
        r4 = xorshift();
        @(posedge clk);
        rom_data     <= r1[15:0];
        ram_data     <= r1[31:16];
        char_dout    <= r2[15:0];
        pal_dout     <= r2[31:16];
        obj_dout     <= r3[15:0];
        joystick1    <= r3[23:16];
        joystick2    <= r3[31:24];
        dipsw_a      <= r4[7:0];
        dipsw_b      <= r4[15:8];
        start_button <= r4[17:16];
        coin_input   <= r4[19:18];
        service      <= r4[20];
        dip_test     <= r4[21];
    endtask

    task automatic start_cycle(input s16b_pkg::region_mask_t act, input s16b_pkg::cpu_addr_t a,
                               input logic rd, input s16b_pkg::bus_word_t wdata, input logic lds);
        @(posedge clk);
        active   <= act;
        addr     <= a;
        rnw      <= rd;
        cpu_dout <= wdata;
        as_n     <= 1'b0;
        uds_n    <= 1'b0;
        lds_n    <= lds;
    endtask

    // Counts cpu_cen steps seen with a select high
    task automatic wait_ack(output int cens);
        int         n;
        logic [7:0] s;
        cens = 0;
        for (n = 0; n < 64; n++) begin
            @(negedge clk);
            if (!dtack_n)
                break;
            s = cur_sels();
            if (cpu_cen && (s[6:0] != 7'd0))
                cens++;
        end
        if (n == 64)
            fail_now("Timeout: dtack_n never went low during the bus cycle");
    endtask

    task automatic end_cycle();
        int n;
        @(posedge clk);
        as_n   <= 1'b1;
        uds_n  <= 1'b1;
        lds_n  <= 1'b1;
        rnw    <= 1'b1;
        active <= '0;
        for (n = 0; n < 16; n++) begin
            @(negedge clk);
            if (dtack_n)
                break;
        end
        if (n == 16)
            fail_now("Timeout: dtack_n stayed low after as_n was released");
    endtask

    task automatic read_word(input s16b_pkg::region_mask_t act, input s16b_pkg::cpu_addr_t a,
                             input logic [7:0] sel, output s16b_pkg::bus_word_t got,
                             output int cens);
        start_cycle(act, a, 1'b1, 16'h0000, 1'b0);
        wait_ack(cens);
        check_sels(cur_sels(), sel);
        check_bit("lds_wn", lds_wn, 1'b1);   // Reads never strobe a write
        check_bit("uds_wn", uds_wn, 1'b1);
        got = cpu_din;
        end_cycle();
    endtask

    task automatic write_word(input s16b_pkg::region_mask_t act, input s16b_pkg::cpu_addr_t a,
                              input s16b_pkg::bus_word_t d, input logic lds);
        int cens;
        start_cycle(act, a, 1'b0, d, lds);
        wait_ack(cens);
        check_bit("lds_wn", lds_wn, lds);
        check_bit("uds_wn", uds_wn, 1'b0);
        end_cycle();
    endtask

    // No DTACK on tile bank writes, the strobe is held for a set time
    task automatic write_tile_bank(input s16b_pkg::cpu_addr_t a, input s16b_pkg::bus_word_t d,
                                   input logic lds);
        start_cycle(8'd1 << s16b_pkg::REG_TBANK, a, 1'b0, d, lds);
        repeat (3) @(posedge clk);
        as_n   <= 1'b1;
        uds_n  <= 1'b1;
        lds_n  <= 1'b1;
        rnw    <= 1'b1;
        active <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic after_reset_state();
        @(negedge clk);
        check_bit("flip", flip, 1'b0);
        check_bit("video_en", video_en, 1'b1);
        check_tile_bank("tile_bank", tile_bank, 6'd0);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_sels(cur_sels(), 8'd0);
        check_word("cpu_din", cpu_din, 16'hffff);
    endtask

    task automatic memory_reads();
        s16b_pkg::region_mask_t act;
        s16b_pkg::cpu_addr_t    a;
        s16b_pkg::bus_word_t    got, exp;
        logic [7:0]             sel;
        logic [31:0]            r;
        int                     cens;
        for (int i = 0; i < 8; i++) begin
            load_random_inputs();
            r = xorshift();
            a = r[22:0];
            a[16] = (i == 6);   // Char area of video RAM
            case (i)
                0, 1, 2: begin act = 8'd1 << i; sel = 8'd1 << SEL_ROM; end
                3:       begin act = 8'd1 << s16b_pkg::REG_RAM;  sel = 8'h02; end
                4:       begin act = 8'd1 << s16b_pkg::REG_ORAM; sel = 8'h20; end
                5:       begin act = 8'd1 << s16b_pkg::REG_VRAM; sel = 8'h04; end
                6:       begin act = 8'd1 << s16b_pkg::REG_VRAM; sel = 8'h08; end
                default: begin act = 8'd1 << s16b_pkg::REG_PAL;  sel = 8'h10; end
            endcase
            read_word(act, a, sel, got, cens);
            case (i)
                0, 1, 2: exp = rom_data;
                3, 5:    exp = ram_data;
                4:       exp = obj_dout;
                6:       exp = char_dout;
                default: exp = pal_dout;
            endcase
            check_word("cpu_din", got, exp);
        end
        // RAM not ready holds off DTACK
        @(posedge clk);
        ram_ok <= 1'b0;
        start_cycle(8'd1 << s16b_pkg::REG_RAM, a, 1'b1, 16'h0000, 1'b0);
        repeat (12) begin
            @(negedge clk);
            check_bit("dtack_n", dtack_n, 1'b1);
        end
        @(posedge clk);
        ram_ok <= 1'b1;
        wait_ack(cens);
        check_word("cpu_din", cpu_din, ram_data);
        end_cycle();
    endtask

    task automatic rom_address_map();
        s16b_pkg::board_id_t ids [8];
        logic [31:0]         r;
        ids = '{8'h00, 8'h0c, 8'h10, 8'h1a, 8'h15, 8'h2b, 8'h3f, 8'h45};
        for (int k = 0; k < 8; k++) begin
            for (int b = 0; b < 3; b++) begin
                r = xorshift();
                @(posedge clk);
                board_id <= ids[k];
                active   <= 8'd1 << b;
                addr     <= r[22:0];
                @(negedge clk);
                check_rom_addr("rom_addr", rom_addr, rom_addr_model(ids[k], 2'(b), r[22:0]));
            end
        end
        @(posedge clk);
        active <= '0;
    endtask

    task automatic cabinet_reads();
        s16b_pkg::cpu_addr_t a;
        s16b_pkg::bus_word_t got;
        s16b_pkg::cab_byte_t exp;
        logic [31:0]         r;
        int                  cens;
        for (int round = 0; round < 2; round++) begin
            for (int j = 0; j < 8; j++) begin
                load_random_inputs();
                r = xorshift();
                a = r[22:0];
                a[13:12] = (j < 4) ? s16b_pkg::IO_INPUTS :
                           (j < 6) ? s16b_pkg::IO_DIP : (j == 6) ? s16b_pkg::IO_CTRL : 2'd3;
                a[2:1] = 2'(j);
                read_word(8'd1 << s16b_pkg::REG_IO, a, 8'd1 << SEL_IO, got, cens);
                exp = cab_model(a);
                check_byte("cpu_din[7:0]", got[7:0], exp);
                check_word("cpu_din", got, {8'hff, exp});
            end
        end
    endtask

    task automatic control_writes();
        s16b_pkg::cpu_addr_t a;
        a = '0;
        a[13:12] = s16b_pkg::IO_CTRL;
        write_word(8'd1 << s16b_pkg::REG_IO, a, 16'h0040, 1'b0);   // Flip on, video off
        check_bit("flip", flip, 1'b1);
        check_bit("video_en", video_en, 1'b0);
        write_word(8'd1 << s16b_pkg::REG_IO, a, 16'h0020, 1'b0);
        check_bit("flip", flip, 1'b0);
        check_bit("video_en", video_en, 1'b1);
        write_word(8'd1 << s16b_pkg::REG_IO, a, 16'h0040, 1'b1);   // Upper byte only
        check_bit("flip", flip, 1'b0);
        check_bit("video_en", video_en, 1'b1);
        a = '0;
        a[1] = 1'b1;
        write_tile_bank(a, 16'h0005, 1'b0);
        check_tile_bank("tile_bank", tile_bank, 6'b101000);
        a[1] = 1'b0;
        write_tile_bank(a, 16'hfffb, 1'b0);
        check_tile_bank("tile_bank", tile_bank, 6'b101011);
        write_tile_bank(a, 16'h0006, 1'b1);
        check_tile_bank("tile_bank", tile_bank, 6'b101011);
        a[1] = 1'b1;
        write_tile_bank(a, 16'h0002, 1'b1);
        check_tile_bank("tile_bank", tile_bank, 6'b101011);
    endtask

    task automatic dtack_delay();
        s16b_pkg::cpu_addr_t a;
        s16b_pkg::bus_word_t got;
        int                  cens;
        int                  prev;
        prev = 0;
        a = '0;
        for (int dc = 0; dc < 3; dc++) begin
            @(posedge clk);
            dtack_cyc <= 2'(dc);
            read_word(8'd1 << s16b_pkg::REG_PAL, a, 8'd1 << SEL_PAL, got, cens);
            check_word("cpu_din", got, pal_dout);
            if (cens < prev)
                fail_now($sformatf("DTACK delay shrank from %0d to %0d cpu_cen pulses",
                                   prev, cens));
            if (cens != dc + 1)
                fail_now($sformatf("** Error at %0t: cpu_cen pulses to dtack_n = %0d, expected %0d",
                                   $time, cens, dc + 1));
            prev = cens;
        end
        @(posedge clk);
        dtack_cyc <= 2'd1;
    endtask

    initial begin
        rst          = 1'b1;
        addr         = '0;
        cpu_dout     = '0;
        rnw          = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        as_n         = 1'b1;
        bgack_n      = 1'b1;
        active       = '0;
        board_id     = 8'h20;
        dtack_cyc    = 2'd1;   // Leaves time for the registered cabinet byte
        rom_data     = '0;
        ram_data     = '0;
        char_dout    = '0;
        pal_dout     = '0;
        obj_dout     = '0;
        rom_ok       = 1'b1;
        ram_ok       = 1'b1;
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        after_reset_state();
        memory_reads();
        rom_address_map();
        cabinet_reads();
        control_writes();
        dtack_delay();
        $display("Test OK");
        $finish;
    end

endmodule

//--- test/s16b_main_checker.sv
// Bus glue protocol assertions
`timescale 1ns/100ps

module s16b_main_checker (
    input logic clk,
    input logic rst,
    input logic as_n,
    input logic dtack_n,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic pal_cs,
    input logic objram_cs,
    input logic io_cs,
    input logic tbank_cs
);

    logic [7:0] sels;
    logic       mem_cs;   // Selects that take part in DTACK

    assign sels   = {tbank_cs, io_cs, objram_cs, pal_cs, char_cs, vram_cs, ram_cs, rom_cs};
    assign mem_cs = |sels[6:0];

    assert property (@(posedge clk) disable iff (rst) $onehot0(sels))
        else $error("Several chip selects high at once: %b", sels);

    // Acknowledge drops one edge after the selects
    assert property (@(posedge clk) disable iff (rst) !mem_cs |=> dtack_n)
        else $error("dtack_n low after a cycle without a chip select");

    assert property (@(posedge clk) disable iff (rst) $past(as_n) |-> sels == 8'd0)
        else $error("Chip select high although as_n was high a cycle before");

endmodule

//--- logic/s16b_main.sv
// Main board bus glue
`timescale 1ns/100ps

module s16b_main (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_cen,
    // CPU bus
    input  s16b_pkg::cpu_addr_t    addr,
    input  s16b_pkg::bus_word_t    cpu_dout,
    input  logic                   rnw,
    input  logic                   uds_n,
    input  logic                   lds_n,
    input  logic                   as_n,
    input  logic                   bgack_n,
    output logic                   uds_wn,
    output logic                   lds_wn,
    output s16b_pkg::bus_word_t    cpu_din,
    output logic                   dtack_n,
    // Mapper and board setup
    input  s16b_pkg::region_mask_t active,
    input  s16b_pkg::board_id_t    board_id,
    input  s16b_pkg::dtack_cyc_t   dtack_cyc,
    // Memories
    output logic                   rom_cs,
    output s16b_pkg::rom_addr_t    rom_addr,
    input  s16b_pkg::bus_word_t    rom_data,
    input  logic                   rom_ok,
    output logic                   ram_cs,
    output logic                   vram_cs,
    input  s16b_pkg::bus_word_t    ram_data,
    input  logic                   ram_ok,
    output logic                   char_cs,
    output logic                   pal_cs,
    output logic                   objram_cs,
    input  s16b_pkg::bus_word_t    char_dout,
    input  s16b_pkg::bus_word_t    pal_dout,
    input  s16b_pkg::bus_word_t    obj_dout,
    // Cabinet
    input  s16b_pkg::cab_byte_t    joystick1,
    input  s16b_pkg::cab_byte_t    joystick2,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic                   dip_test,
    input  s16b_pkg::cab_byte_t    dipsw_a,
    input  s16b_pkg::cab_byte_t    dipsw_b,
    // Video control
    output logic                   flip,
    output logic                   video_en,
    output s16b_pkg::tile_bank_t   tile_bank
);

    logic                io_cs;
    logic                tbank_cs;
    s16b_pkg::cab_byte_t cab_dout;

    s16b_bus_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rnw       (rnw),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .as_n      (as_n),
        .bgack_n   (bgack_n),
        .active    (active),
        .board_id  (board_id),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs),
        .lds_wn    (lds_wn),
        .uds_wn    (uds_wn),
        .rom_addr  (rom_addr)
    );

    s16b_cab_io u_cab_io (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .cpu_dout     (cpu_dout),
        .io_cs        (io_cs),
        .tbank_cs     (tbank_cs),
        .lds_wn       (lds_wn),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

    s16b_data_ack u_data_ack (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .dtack_cyc (dtack_cyc),
        .cpu_din   (cpu_din),
        .dtack_n   (dtack_n)
    );

endmodule

//--- logic/s16b_data_ack.sv
// CPU read data and DTACK
`timescale 1ns/100ps

module s16b_data_ack (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_cen,
    input  logic                   rom_cs,
    input  logic                   ram_cs,
    input  logic                   vram_cs,
    input  logic                   char_cs,
    input  logic                   pal_cs,
    input  logic                   objram_cs,
    input  logic                   io_cs,
    input  s16b_pkg::bus_word_t    rom_data,
    input  s16b_pkg::bus_word_t    ram_data,
    input  s16b_pkg::bus_word_t    char_dout,
    input  s16b_pkg::bus_word_t    pal_dout,
    input  s16b_pkg::bus_word_t    obj_dout,
    input  s16b_pkg::cab_byte_t    cab_dout,
    input  logic                   rom_ok,
    input  logic                   ram_ok,
    input  s16b_pkg::dtack_cyc_t   dtack_cyc,
    output s16b_pkg::bus_word_t    cpu_din,
    output logic                   dtack_n
);

    logic bus_cs;
    logic bus_busy;
    logic ack_n;     // Base acknowledge
    logic ack_n_d1;
    logic ack_n_d2;

    assign bus_cs   = rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs | io_cs;
    assign bus_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    // Unmapped accesses keep the last word
    always_ff @(posedge clk, posedge rst) begin
        if (rst)                    cpu_din <= 16'hffff;
        else if (ram_cs | vram_cs)  cpu_din <= ram_data;
        else if (rom_cs)            cpu_din <= rom_data;
        else if (char_cs)           cpu_din <= char_dout;
        else if (pal_cs)            cpu_din <= pal_dout;
        else if (objram_cs)         cpu_din <= obj_dout;
        else if (io_cs)             cpu_din <= {8'hff, cab_dout};
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ack_n    <= 1'b1;
            ack_n_d1 <= 1'b1;
            ack_n_d2 <= 1'b1;
        end else if (!bus_cs) begin
            ack_n    <= 1'b1;
            ack_n_d1 <= 1'b1;
            ack_n_d2 <= 1'b1;
        end else if (cpu_cen) begin
            if (!bus_busy)
                ack_n <= 1'b0;  // Held low until the selects drop
            ack_n_d1 <= ack_n;
            ack_n_d2 <= ack_n_d1;
        end
    end

    always_comb begin
        case (dtack_cyc)
            2'd0:    dtack_n = ack_n;
            2'd1:    dtack_n = ack_n_d1;
            default: dtack_n = ack_n_d2;
        endcase
    end

endmodule

//--- logic/s16b_cab_io.sv
// Cabinet inputs and video control
`timescale 1ns/100ps

module s16b_cab_io (
    input  logic                   clk,
    input  logic                   rst,
    input  s16b_pkg::cpu_addr_t    addr,
    input  s16b_pkg::bus_word_t    cpu_dout,
    input  logic                   io_cs,
    input  logic                   tbank_cs,
    input  logic                   lds_wn,
    input  s16b_pkg::cab_byte_t    joystick1,
    input  s16b_pkg::cab_byte_t    joystick2,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic                   dip_test,
    input  s16b_pkg::cab_byte_t    dipsw_a,
    input  s16b_pkg::cab_byte_t    dipsw_b,
    output s16b_pkg::cab_byte_t    cab_dout,
    output logic                   flip,
    output logic                   video_en,
    output s16b_pkg::tile_bank_t   tile_bank
);

    s16b_pkg::io_page_t  page;
    s16b_pkg::cab_byte_t sort1;
    s16b_pkg::cab_byte_t sort2;
    s16b_pkg::cab_byte_t cab_next;

    // Reorders the joystick bits into the board's input layout
    function automatic s16b_pkg::cab_byte_t sort_joy(input s16b_pkg::cab_byte_t joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    assign page  = addr[13:12];
    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    always_comb begin
        cab_next = s16b_pkg::CAB_IDLE;
        if (page == s16b_pkg::IO_INPUTS) begin
            case (addr[2:1])
                2'd0:    cab_next = {2'b11, start_button, service, dip_test, coin_input};
                2'd1:    cab_next = sort1;
                2'd3:    cab_next = sort2;
                default: cab_next = s16b_pkg::CAB_IDLE;
            endcase
        end else if (page == s16b_pkg::IO_DIP) begin
            cab_next = addr[1] ? dipsw_a : dipsw_b;
        end
    end

    // Read byte, idle outside I/O cycles
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cab_dout <= s16b_pkg::CAB_IDLE;
        end else if (io_cs) begin
            cab_dout <= cab_next;
        end else begin
            cab_dout <= s16b_pkg::CAB_IDLE;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b1;   // Screen on out of reset
        end else if (io_cs && page == s16b_pkg::IO_CTRL && !lds_wn) begin
            flip     <= cpu_dout[6];
            video_en <= cpu_dout[5];
        end
    end

    // Tile bank is written in two 3-bit halves
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (tbank_cs && !lds_wn) begin
            if (addr[1])
                tile_bank[5:3] <= cpu_dout[2:0];
            else
                tile_bank[2:0] <= cpu_dout[2:0];
        end
    end

endmodule

//--- logic/s16b_bus_decode.sv
// Bus region decode
`timescale 1ns/100ps

module s16b_bus_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  s16b_pkg::cpu_addr_t      addr,
    input  logic                     rnw,
    input  logic                     uds_n,
    input  logic                     lds_n,
    input  logic                     as_n,
    input  logic                     bgack_n,
    input  s16b_pkg::region_mask_t   active,
    input  s16b_pkg::board_id_t      board_id,
    output logic                     rom_cs,
    output logic                     ram_cs,
    output logic                     vram_cs,
    output logic                     char_cs,
    output logic                     pal_cs,
    output logic                     objram_cs,
    output logic                     io_cs,
    output logic                     tbank_cs,
    output logic                     lds_wn,
    output logic                     uds_wn,
    output s16b_pkg::rom_addr_t      rom_addr
);

    logic       bus_n;   // Low while a data strobe is active
    logic [1:0] act_enc;

    assign lds_wn = rnw | lds_n;
    assign uds_wn = rnw | uds_n;
    assign bus_n  = as_n | (lds_n & uds_n);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (!as_n && bgack_n) begin
            rom_cs    <= |active[2:0] && rnw;
            char_cs   <= active[s16b_pkg::REG_VRAM] && addr[16];
            objram_cs <= active[s16b_pkg::REG_ORAM];
            pal_cs    <= active[s16b_pkg::REG_PAL];
            io_cs     <= active[s16b_pkg::REG_IO];
            tbank_cs  <= active[s16b_pkg::REG_TBANK] && !rnw;
            // RAM selects follow the strobes so read-modify-write toggles them
            vram_cs   <= !bus_n && active[s16b_pkg::REG_VRAM] && !addr[16];
            ram_cs    <= !bus_n && active[s16b_pkg::REG_RAM];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end
    end

    // ROM bank number
    always_comb begin
        case (active[2:0])
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    always_comb begin
        casez (board_id[7:3])
            5'b001??: rom_addr = addr[18:1];            // 0x20 to 0x3F
            5'b00001: rom_addr = {1'b0, addr[17:1]};    // 0x08 to 0x0F
            5'b0001?: begin
                if (board_id == s16b_pkg::BOARD_LARGE_A || board_id == s16b_pkg::BOARD_LARGE_B)
                    rom_addr = {act_enc, addr[16:1]};
                else
                    rom_addr = {1'b0, act_enc, addr[15:1]}; // Small 5358 map
            end
            default:  rom_addr = {act_enc[0], addr[17:1]};
        endcase
    end

endmodule

//--- logic/s16b_pkg.sv
// Bus glue shared types
// Region, board and I/O page codes
package s16b_pkg;

    typedef logic [23:1] cpu_addr_t;    // CPU word address
    typedef logic [15:0] bus_word_t;
    typedef logic [ 7:0] cab_byte_t;    // Cabinet or DIP byte
    typedef logic [ 7:0] region_mask_t; // One-hot mapper regions
    typedef logic [18:1] rom_addr_t;    // ROM word address
    typedef logic [ 5:0] tile_bank_t;
    typedef logic [ 1:0] dtack_cyc_t;   // Extra DTACK steps
    typedef logic [ 7:0] board_id_t;
    typedef logic [ 1:0] io_page_t;

    // Bit positions in region_mask_t
    // Regions 0 to 2 map the program ROM banks
    localparam int REG_TBANK = 2;  // Top ROM bank, tile bank on writes
    localparam int REG_RAM   = 3;
    localparam int REG_ORAM  = 4;
    localparam int REG_VRAM  = 5;
    localparam int REG_PAL   = 6;
    localparam int REG_IO    = 7;

    // Boards whose 5358 layout uses the large ROM map
    localparam board_id_t BOARD_LARGE_A = 8'h10;
    localparam board_id_t BOARD_LARGE_B = 8'h1a;

    // I/O pages, taken from addr[13:12]
    localparam io_page_t IO_CTRL   = 2'd0;
    localparam io_page_t IO_INPUTS = 2'd1;
    localparam io_page_t IO_DIP    = 2'd2;

    // Data returned for unmapped cabinet reads
    localparam cab_byte_t CAB_IDLE = 8'hff;

endpackage
